// File: testbench/sound_stimulus.txt
// Columns test_op_addr_data_expect in hex. Ops are 0 write, 1 read, 2 wait data cycles plus
// expect random bits, 3 window of data cycles on so1 (addr 1) or so2 (addr 2), expect = vols.
1_1_ff26_00_000000
1_0_ff24_5a_000000
1_1_ff24_00_00005a
1_0_ff25_ff_000000
1_1_ff25_00_0000bb
1_0_ff26_ff_000000
1_1_ff26_00_000080
1_0_ff12_ff_000000
1_1_ff12_00_0000f0
1_2_0000_01_000003
1_1_ff15_00_000000
2_0_ff14_80_000000
2_1_ff26_00_000081
2_0_ff19_80_000000
2_1_ff26_00_000083
2_0_ff23_80_000000
2_1_ff26_00_00008b
2_0_ff26_00_000000
2_2_0000_02_000000
2_1_ff26_00_000000
3_0_ff26_80_000000
3_0_ff11_b8_000000
3_0_ff14_c0_000000
3_1_ff26_00_000081
3_2_0000_1a_000000
3_1_ff26_00_000081
3_2_0000_0a_000000
3_1_ff26_00_000080
3_0_ff20_3c_000000
3_0_ff23_c0_000000
3_1_ff26_00_000088
3_2_0000_0a_000000
3_1_ff26_00_000088
3_2_0000_08_000000
3_1_ff26_00_000080
4_0_ff24_88_000000
4_0_ff25_01_000000
4_0_ff11_80_000000
4_0_ff13_fe_000000
4_0_ff14_87_000000
4_3_0001_40_0000f0
4_3_0002_20_000000
5_0_ff16_80_000000
5_0_ff17_80_000000
5_0_ff18_fe_000000
5_0_ff25_03_000000
5_0_ff14_87_000000
5_0_ff19_87_000000
5_3_0001_40_0000f8
5_3_0002_20_000000
5_0_ff24_80_000000
5_2_0000_01_000000
5_3_0001_10_000000
5_0_ff24_88_000000
5_3_0001_40_0000f8
5_0_ff26_00_000000
5_2_0000_01_000000
5_3_0001_10_000000

// File: files.f
common/sound_pkg.sv
verilog/io_bus_parser_reg.sv
sound_channel/square_channel.sv
sound_channel/noise_channel.sv
verilog/sound_mixer.sv
verilog/sound_controller.sv
testbench/tb_clock_gen.sv
testbench/sound_controller_sva.sv
testbench/sound_controller_tb.sv

// File: Bender.yml
package:
  name: sound_controller

sources:
  - files:
      - common/sound_pkg.sv
      - verilog/io_bus_parser_reg.sv
      - sound_channel/square_channel.sv
      - sound_channel/noise_channel.sv
      - verilog/sound_mixer.sv
      - verilog/sound_controller.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sound_controller_sva.sv
      - testbench/sound_controller_tb.sv

// File: testbench/sound_controller_tb.sv
`timescale 1ns/1ps

module sound_controller_tb;

   localparam int SAMPLE_W   = 20;
   localparam int LENGTH_DIV = 4;
   localparam int MAX_OPS    = 128;

   localparam logic [3:0] OP_WRITE  = 4'h0;
   localparam logic [3:0] OP_READ   = 4'h1;
   localparam logic [3:0] OP_WAIT   = 4'h2;
   localparam logic [3:0] OP_WINDOW = 4'h3;

   logic                clk;
   logic                rst_n;
   sound_pkg::addr_t    addr;
   sound_pkg::reg_t     wr_data;
   sound_pkg::reg_t     rd_data;
   logic                re_l;
   logic                we_l;
   logic [SAMPLE_W-1:0] so1;
   logic [SAMPLE_W-1:0] so2;

   // Test, op, address, data, expect.
   logic [55:0] ops [MAX_OPS];
   int          num_ops;
   logic [31:0] lfsr_state;
   int          errors;
   int          checks;
   int          test_errors;
   int          tests_run;
   bit          loaded;

   tb_clock_gen #(.PERIOD_NS(10.0)) u_clk (.clk);

   sound_controller #(.SAMPLE_W(SAMPLE_W), .LENGTH_DIV(LENGTH_DIV)) uut (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .rd_data, .so1, .so2);

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_random(input int nbits, output int value);
      value = 0;
      for (int i = 0; i < nbits; i++) begin
         value = (value << 1) | lfsr_state[0];
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // Volume in the top bits, quartered by the mixer.
   function automatic logic [SAMPLE_W-1:0] mixed_level(input logic [3:0] vol);
      mixed_level = {vol, {(SAMPLE_W-4){1'b0}}} >> 2;
   endfunction

   function automatic string test_name(input logic [3:0] id);
      case (id)
         4'h1: test_name = "register readback";
         4'h2: test_name = "trigger and status";
         4'h3: test_name = "length expiry";
         4'h4: test_name = "routing";
         4'h5: test_name = "mixing and gating";
         default: test_name = "unnamed";
      endcase
   endfunction

   task automatic bus_write(input sound_pkg::addr_t a, input sound_pkg::reg_t d);
      addr    = a;
      wr_data = d;
      we_l    = 1'b0;
      @(negedge clk);
      we_l    = 1'b1;
      addr    = 16'h0000;
   endtask

   task automatic bus_read_check(input sound_pkg::addr_t a, input sound_pkg::reg_t exp);
      sound_pkg::reg_t got;
      addr = a;
      re_l = 1'b0;
      @(negedge clk);
      got  = rd_data;
      re_l = 1'b1;
      addr = 16'h0000;
      checks++;
      if (got !== exp) begin
         $display("error at %0t ns: read 0x%h from 0x%h, expected 0x%h", $time, got, a, exp);
         test_errors++;
      end
   endtask

   task automatic check_window(input logic [15:0] which, input int cycles,
                               input logic [7:0] vols);
      logic [SAMPLE_W-1:0] l1;
      logic [SAMPLE_W-1:0] l2;
      logic [SAMPLE_W-1:0] val;
      bit                  seen_zero;
      bit                  seen_level;
      bit                  bad;
      l1         = mixed_level(vols[7:4]);
      l2         = mixed_level(vols[3:0]);
      seen_zero  = 1'b0;
      seen_level = 1'b0;
      bad        = 1'b0;
      for (int i = 0; i < cycles; i++) begin
         val = (which == 16'h0002) ? so2 : so1;
         if (val == '0) begin
            seen_zero = 1'b1;
         end else if (val == l1 || val == l2 || val == l1 + l2) begin
            seen_level = 1'b1;
         end else if (!bad) begin
            $display("error at %0t ns: so%0d is 0x%h, expected 0, 0x%h, 0x%h or their sum",
                     $time, which, val, l1, l2);
            bad = 1'b1;
         end
         @(negedge clk);
      end
      checks++;
      if (bad) test_errors++;
      if (vols != 8'h00 && !(seen_zero && seen_level)) begin
         $display("so%0d did not show both silence and a channel level in %0d cycles",
                  which, cycles);
         test_errors++;
      end
   endtask

   task automatic finish_test(input logic [3:0] id);
      tests_run++;
      if (test_errors == 0) $display("test %0d %s: ok", id, test_name(id));
      else $display("test %0d %s: %0d failed checks", id, test_name(id), test_errors);
      errors += test_errors;
      test_errors = 0;
   endtask

   initial begin
      logic [55:0] op_word;
      logic [3:0]  cur_test;
      int          gap;
      rst_n       = 1'b0;
      addr        = 16'h0000;
      wr_data     = 8'h00;
      re_l        = 1'b1;
      we_l        = 1'b1;
      lfsr_state  = 32'ha0e;
      errors      = 0;
      checks      = 0;
      test_errors = 0;
      tests_run   = 0;
      cur_test    = 4'h0;
      $readmemh("testbench/sound_stimulus.txt", ops);
      num_ops = 0;
      while (num_ops < MAX_OPS && !$isunknown(ops[num_ops])) num_ops++;
      if (num_ops == 0) begin
         $display("no stimulus lines could be read");
         errors++;
      end
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      if (num_ops > 0) cur_test = ops[0][55:52];
      for (int i = 0; i < num_ops; i++) begin
         op_word = ops[i];
         if (op_word[55:52] != cur_test) begin
            finish_test(cur_test);
            cur_test = op_word[55:52];
         end
         case (op_word[51:48])
            OP_WRITE: bus_write(op_word[47:32], op_word[31:24]);
            OP_READ: bus_read_check(op_word[47:32], op_word[7:0]);
            OP_WAIT: begin
               take_random(op_word[23:0], gap);
               repeat (op_word[31:24] + gap) @(negedge clk);
            end
            OP_WINDOW: check_window(op_word[47:32], op_word[31:24], op_word[7:0]);
            default: begin
               $display("stimulus line %0d has unknown operation %0h", i, op_word[51:48]);
               test_errors++;
            end
         endcase
      end
      if (num_ops > 0) finish_test(cur_test);
      if (uut.u_sva.failures > 0) begin
         $display("%0d assertion failures in the bound checker", uut.u_sva.failures);
         errors += uut.u_sva.failures;
      end
      $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Budget per stimulus line plus one full length run and reset.
   initial begin
      wait (loaded);
      repeat (num_ops * 200 + 64 * LENGTH_DIV + 10) @(posedge clk);
      $display("timeout: stimulus did not finish in %0d lines' time", num_ops);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: testbench/sound_controller_sva.sv
`timescale 1ns/1ps

module sound_controller_sva #(
   parameter int SAMPLE_W = 20
) (
   input logic                clk,
   input logic                rst_n,
   input sound_pkg::addr_t    addr,
   input logic                re_l,
   input sound_pkg::reg_t     rd_data,
   input logic                master_en,
   input logic [SAMPLE_W-1:0] so1,
   input logic [SAMPLE_W-1:0] so2
);

   int failures = 0;

   // Read bus is quiet outside a read strobe.
   idle_bus_zero: assert property (@(posedge clk) disable iff (!rst_n)
      re_l |-> (rd_data == 8'h00))
      else begin
         failures++;
         $error("rd_data is 0x%h while re_l is high", rd_data);
      end

   // Mixer output dies one cycle after the master switch.
   master_off_silent: assert property (@(posedge clk) disable iff (!rst_n)
      !master_en |=> (so1 == '0 && so2 == '0))
      else begin
         failures++;
         $error("so1 0x%h so2 0x%h after master_en went low", so1, so2);
      end

   // Wave channel is absent.
   wave_status_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (!re_l && addr == sound_pkg::NR52_ADDR) |-> !rd_data[2])
      else begin
         failures++;
         $error("NR52 bit 2 reads as one");
      end

endmodule

bind sound_controller sound_controller_sva #(.SAMPLE_W(SAMPLE_W)) u_sva (
   .clk, .rst_n, .addr, .re_l, .rd_data, .master_en, .so1, .so2);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS = 10.0
) (
   output logic clk
);

   initial clk = 1'b0;

   // Free-running, starts low.
   always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// File: verilog/sound_controller.sv
`timescale 1ns/1ps

module sound_controller #(
   parameter int SAMPLE_W   = 20,
   parameter int LENGTH_DIV = 64
) (
   input  logic                clk,
   input  logic                rst_n,
   input  sound_pkg::addr_t    addr,
   input  sound_pkg::reg_t     wr_data,
   input  logic                re_l,
   input  logic                we_l,
   output sound_pkg::reg_t     rd_data,
   output logic [SAMPLE_W-1:0] so1,
   output logic [SAMPLE_W-1:0] so2
);

   sound_pkg::reg_t nr50, nr51, nr52;
   sound_pkg::reg_t nr50_rd, nr51_rd, nr52_rd;
   sound_pkg::reg_t ch1_rd, ch2_rd, ch4_rd;
   sound_pkg::reg_t nr52_hw;
   logic            master_en;
   logic            ch1_on, ch2_on, ch4_on;
   logic [sound_pkg::NUM_CH-1:0] ch_status;
   logic [SAMPLE_W-1:0] ch1_sample, ch2_sample, ch4_sample;

   // Volume bits are kept but never applied.
   io_bus_parser_reg #(.ADDR(sound_pkg::NR50_ADDR), .READ_MASK(8'hff),
                       .WRITE_MASK(8'hff)) u_nr50 (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(nr50_rd), .value(nr50), .written());

   io_bus_parser_reg #(.ADDR(sound_pkg::NR51_ADDR), .READ_MASK(8'hbb),
                       .WRITE_MASK(8'hbb)) u_nr51 (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(nr51_rd), .value(nr51), .written());

   // Slot 2 is the wave channel, always off.
   assign ch_status = {ch4_on, 1'b0, ch2_on, ch1_on};
   assign nr52_hw   = {{(8 - sound_pkg::NUM_CH){1'b0}}, ch_status};

   // Master enable is written, status bits come from the channels.
   io_bus_parser_reg #(.ADDR(sound_pkg::NR52_ADDR), .READ_MASK(8'h8b),
                       .WRITE_MASK(8'h80), .FORWARD_MASK(8'h0b)) u_nr52 (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(nr52_hw),
      .rd_data(nr52_rd), .value(nr52), .written());

   assign master_en = nr52[sound_pkg::MASTER_EN_BIT];

   square_channel #(.BASE(sound_pkg::CH1_BASE), .SAMPLE_W(SAMPLE_W),
                    .LENGTH_DIV(LENGTH_DIV)) u_ch1 (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .master_en,
      .rd_data(ch1_rd), .ch_on(ch1_on), .sample(ch1_sample));

   square_channel #(.BASE(sound_pkg::CH2_BASE), .SAMPLE_W(SAMPLE_W),
                    .LENGTH_DIV(LENGTH_DIV)) u_ch2 (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .master_en,
      .rd_data(ch2_rd), .ch_on(ch2_on), .sample(ch2_sample));

   noise_channel #(.BASE(sound_pkg::CH4_BASE), .SAMPLE_W(SAMPLE_W),
                   .LENGTH_DIV(LENGTH_DIV)) u_ch4 (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .master_en,
      .rd_data(ch4_rd), .ch_on(ch4_on), .sample(ch4_sample));

   sound_mixer #(.SAMPLE_W(SAMPLE_W)) u_mixer (
      .clk,
      .rst_n,
      .ch1_sample,
      .ch2_sample,
      .ch4_sample,
      .route(nr51),
      .so1_en(nr50[3]),
      .so2_en(nr50[7]),
      .master_en,
      .so1,
      .so2
   );

   // Non-selected registers drive zero.
   assign rd_data = nr50_rd | nr51_rd | nr52_rd | ch1_rd | ch2_rd | ch4_rd;

endmodule

// File: verilog/sound_mixer.sv
`timescale 1ns/1ps

module sound_mixer #(
   parameter int SAMPLE_W = 20
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [SAMPLE_W-1:0] ch1_sample,
   input  logic [SAMPLE_W-1:0] ch2_sample,
   input  logic [SAMPLE_W-1:0] ch4_sample,
   input  sound_pkg::reg_t     route,
   input  logic                so1_en,
   input  logic                so2_en,
   input  logic                master_en,
   output logic [SAMPLE_W-1:0] so1,
   output logic [SAMPLE_W-1:0] so2
);

   logic [SAMPLE_W-1:0] so1_sum;
   logic [SAMPLE_W-1:0] so2_sum;

   // Each channel at a quarter so four full channels cannot overflow.
   // Route bits 2 and 6 belong to the absent wave channel.
   always_comb begin
      so1_sum = '0;
      so2_sum = '0;
      if (route[0]) so1_sum = so1_sum + (ch1_sample >> 2);
      if (route[1]) so1_sum = so1_sum + (ch2_sample >> 2);
      if (route[3]) so1_sum = so1_sum + (ch4_sample >> 2);
      if (route[4]) so2_sum = so2_sum + (ch1_sample >> 2);
      if (route[5]) so2_sum = so2_sum + (ch2_sample >> 2);
      if (route[7]) so2_sum = so2_sum + (ch4_sample >> 2);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         so1 <= '0;
         so2 <= '0;
      end else begin
         so1 <= (so1_en && master_en) ? so1_sum : '0;
         so2 <= (so2_en && master_en) ? so2_sum : '0;
      end
   end

endmodule

// File: sound_channel/noise_channel.sv
`timescale 1ns/1ps

module noise_channel #(
   parameter sound_pkg::addr_t BASE = 16'hff20,
   parameter int SAMPLE_W   = 20,
   parameter int LENGTH_DIV = 64
) (
   input  logic                clk,
   input  logic                rst_n,
   input  sound_pkg::addr_t    addr,
   input  sound_pkg::reg_t     wr_data,
   input  logic                re_l,
   input  logic                we_l,
   input  logic                master_en,
   output sound_pkg::reg_t     rd_data,
   output logic                ch_on,
   output logic [SAMPLE_W-1:0] sample
);

   localparam int DIV_W = $clog2(LENGTH_DIV);

   sound_pkg::reg_t  len_reg, vol_reg, poly, ctrl;
   sound_pkg::reg_t  rd0, rd1, rd2, rd3;
   logic             ctrl_written;
   logic             trigger;
   logic             len_tick;
   logic             lfsr_tick;
   logic             fb;
   logic [14:0]      lfsr, lfsr_next;
   logic [21:0]      lfsr_period;
   logic [21:0]      freq_cnt;
   logic [5:0]       len_cnt;
   logic [DIV_W-1:0] div_cnt;

   io_bus_parser_reg #(.ADDR(BASE), .READ_MASK(8'h3f), .WRITE_MASK(8'h3f)) u_len (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd0), .value(len_reg), .written());
   io_bus_parser_reg #(.ADDR(BASE + 16'd1), .READ_MASK(8'hf0), .WRITE_MASK(8'hf0)) u_vol (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd1), .value(vol_reg), .written());
   io_bus_parser_reg #(.ADDR(BASE + 16'd2), .READ_MASK(8'hff), .WRITE_MASK(8'hff)) u_poly (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd2), .value(poly), .written());
   io_bus_parser_reg #(.ADDR(BASE + 16'd3), .READ_MASK(8'h40), .WRITE_MASK(8'h40)) u_ctrl (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd3), .value(ctrl), .written(ctrl_written));

   assign trigger  = ctrl_written && wr_data[sound_pkg::TRIGGER_BIT];
   assign len_tick = (div_cnt == DIV_W'(LENGTH_DIV - 1));

   // Divisor code 0 means 8, otherwise 16 per step, then shifted.
   assign lfsr_period = (poly[2:0] == 3'd0 ? 22'd8 : {15'd0, poly[2:0], 4'd0}) << poly[7:4];
   assign lfsr_tick   = (freq_cnt >= lfsr_period - 22'd1);

   assign fb = lfsr[0] ^ lfsr[1];
   always_comb begin
      lfsr_next = {fb, lfsr[14:1]};
      // Short mode.
      if (poly[3]) lfsr_next[6] = fb;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ch_on    <= 1'b0;
         lfsr     <= '1;
         freq_cnt <= '0;
         len_cnt  <= '0;
         div_cnt  <= '0;
      end else if (trigger && master_en) begin
         ch_on    <= 1'b1;
         lfsr     <= '1;
         freq_cnt <= '0;
         len_cnt  <= len_reg[5:0];
         div_cnt  <= '0;
      end else begin
         if (ch_on) begin
            freq_cnt <= lfsr_tick ? '0 : freq_cnt + 22'd1;
            if (lfsr_tick) lfsr <= lfsr_next;
            div_cnt <= len_tick ? '0 : div_cnt + 1'b1;
            if (len_tick) begin
               if (len_cnt != 6'h3f) len_cnt <= len_cnt + 6'd1;
               else if (ctrl[sound_pkg::LENGTH_EN_BIT]) ch_on <= 1'b0;
            end
         end
         if (!master_en) ch_on <= 1'b0;
      end
   end

   assign sample  = (ch_on && !lfsr[0]) ? {vol_reg[7:4], {(SAMPLE_W-4){1'b0}}} : '0;
   assign rd_data = rd0 | rd1 | rd2 | rd3;

endmodule

// File: sound_channel/square_channel.sv
`timescale 1ns/1ps

module square_channel #(
   parameter sound_pkg::addr_t BASE = 16'hff11,
   parameter int SAMPLE_W   = 20,
   parameter int LENGTH_DIV = 64
) (
   input  logic                clk,
   input  logic                rst_n,
   input  sound_pkg::addr_t    addr,
   input  sound_pkg::reg_t     wr_data,
   input  logic                re_l,
   input  logic                we_l,
   input  logic                master_en,
   output sound_pkg::reg_t     rd_data,
   output logic                ch_on,
   output logic [SAMPLE_W-1:0] sample
);

   localparam int DIV_W = $clog2(LENGTH_DIV);

   sound_pkg::reg_t  duty_len, vol_reg, freq_lo, freq_hi;
   sound_pkg::reg_t  rd0, rd1, rd2, rd3;
   logic             hi_written;
   logic             trigger;
   logic             len_tick;
   logic             duty_high;
   logic [10:0]      timer;
   logic [2:0]       step;
   logic [5:0]       len_cnt;
   logic [DIV_W-1:0] div_cnt;

   io_bus_parser_reg #(.ADDR(BASE), .READ_MASK(8'hff), .WRITE_MASK(8'hff)) u_len (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd0), .value(duty_len), .written());
   io_bus_parser_reg #(.ADDR(BASE + 16'd1), .READ_MASK(8'hf0), .WRITE_MASK(8'hf0)) u_vol (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd1), .value(vol_reg), .written());
   io_bus_parser_reg #(.ADDR(BASE + 16'd2), .READ_MASK(8'hff), .WRITE_MASK(8'hff)) u_flo (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd2), .value(freq_lo), .written());
   // Trigger bit is not stored.
   io_bus_parser_reg #(.ADDR(BASE + 16'd3), .READ_MASK(8'h47), .WRITE_MASK(8'h47)) u_fhi (
      .clk, .rst_n, .addr, .wr_data, .re_l, .we_l, .hw_data(8'h00),
      .rd_data(rd3), .value(freq_hi), .written(hi_written));

   assign trigger   = hi_written && wr_data[sound_pkg::TRIGGER_BIT];
   assign len_tick  = (div_cnt == DIV_W'(LENGTH_DIV - 1));
   assign duty_high = sound_pkg::DUTY_PATTERNS[duty_len[7:6]][step];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ch_on   <= 1'b0;
         timer   <= '0;
         step    <= '0;
         len_cnt <= '0;
         div_cnt <= '0;
      end else if (trigger && master_en) begin
         // Frequency high comes straight from the bus on this write.
         ch_on   <= 1'b1;
         timer   <= {wr_data[2:0], freq_lo};
         step    <= '0;
         len_cnt <= duty_len[5:0];
         div_cnt <= '0;
      end else begin
         if (ch_on) begin
            if (timer == 11'h7ff) begin
               timer <= {freq_hi[2:0], freq_lo};
               step  <= step + 3'd1;
            end else begin
               timer <= timer + 11'd1;
            end
            div_cnt <= len_tick ? '0 : div_cnt + 1'b1;
            if (len_tick) begin
               if (len_cnt != 6'h3f) len_cnt <= len_cnt + 6'd1;
               else if (freq_hi[sound_pkg::LENGTH_EN_BIT]) ch_on <= 1'b0;
            end
         end
         if (!master_en) ch_on <= 1'b0;
      end
   end

   assign sample  = (ch_on && duty_high) ? {vol_reg[7:4], {(SAMPLE_W-4){1'b0}}} : '0;
   assign rd_data = rd0 | rd1 | rd2 | rd3;

endmodule

// File: verilog/io_bus_parser_reg.sv
`timescale 1ns/1ps

module io_bus_parser_reg #(
   parameter sound_pkg::addr_t ADDR         = 16'h0000,
   parameter sound_pkg::reg_t  RESET_VAL    = 8'h00,
   parameter sound_pkg::reg_t  READ_MASK    = 8'hff,
   parameter sound_pkg::reg_t  WRITE_MASK   = 8'hff,
   parameter sound_pkg::reg_t  FORWARD_MASK = 8'h00
) (
   input  logic             clk,
   input  logic             rst_n,
   input  sound_pkg::addr_t addr,
   input  sound_pkg::reg_t  wr_data,
   input  logic             re_l,
   input  logic             we_l,
   input  sound_pkg::reg_t  hw_data,
   output sound_pkg::reg_t  rd_data,
   output sound_pkg::reg_t  value,
   output logic             written
);

   sound_pkg::reg_t q;
   sound_pkg::reg_t q_next;
   logic            hit;

   assign hit     = (addr == ADDR);
   assign written = hit && !we_l;

   // CPU bits first, then hardware bits win.
   always_comb begin
      q_next = q;
      if (written) q_next = (q & ~WRITE_MASK) | (wr_data & WRITE_MASK);
      q_next = (q_next & ~FORWARD_MASK) | (hw_data & FORWARD_MASK);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         q <= RESET_VAL;
      end else begin
         q <= q_next;
      end
   end

   assign value   = q;
   assign rd_data = (hit && !re_l) ? (q & READ_MASK) : 8'h00;

endmodule

// File: common/sound_pkg.sv
package sound_pkg;

   // CPU bus types.
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  reg_t;

   // Master registers.
   parameter addr_t NR50_ADDR = 16'hff24;
   parameter addr_t NR51_ADDR = 16'hff25;
   parameter addr_t NR52_ADDR = 16'hff26;

   // Channel register blocks, four registers each.
   // Offsets: 0 duty or length, 1 volume, 2 freq low or poly, 3 control.
   parameter addr_t CH1_BASE = 16'hff11;
   parameter addr_t CH2_BASE = 16'hff16;
   parameter addr_t CH4_BASE = 16'hff20;

   // Control register fields.
   parameter int TRIGGER_BIT   = 7;
   parameter int LENGTH_EN_BIT = 6;

   // NR52 master enable.
   parameter int MASTER_EN_BIT = 7;

   // Eight-step duty waveforms, indexed by the two duty bits.
   // 12.5 %, 25 %, 50 % and 75 %.
   parameter logic [3:0][7:0] DUTY_PATTERNS = {
      8'b0111_1110,
      8'b1000_0111,
      8'b1000_0001,
      8'b0000_0001
   };

   // Status and routing slots per output.
   parameter int NUM_CH = 4;

endpackage
